/* design/fetch_port.sv */
//////////////////////////////
// Instruction fetch port
// Credit-controlled reads to RAM, in-order responses
//////////////////////////////

module fetch_port #(
  parameter int RAM_WORDS = 256,
  parameter int CREDITS   = 2
) (
  input  logic              HCLK,
  input  logic              arst_n_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  mem_pkg::addr_t    addr_i,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output mem_pkg::mem_rsp_t rsp_o,
  output logic              mreq_valid_o,
  output mem_pkg::addr_t    maddr_o,
  input  logic              crd_i,
  input  logic              mrsp_valid_i,
  input  mem_pkg::data_t    mrsp_data_i
);

  localparam int CNT_W = $clog2(CREDITS + 1);
  localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;

  typedef enum logic {IDLE, ERR_RSP} state_e;

  state_e           state_q;
  mem_pkg::region_t region;
  logic             misaligned;
  logic             ram_ok;
  logic             req_fire;
  logic             rsp_fire;
  logic             rq_pop;
  logic [CNT_W-1:0] outstanding;
  logic [CNT_W-1:0] credit;
  logic [CNT_W-1:0] rq_count;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  mem_pkg::data_t   rq_data [CREDITS];

  pma_check #(.RAM_WORDS(RAM_WORDS)) u_pma (
    .addr_i       (addr_i),
    .region_o     (region),
    .misaligned_o (misaligned)
  );

  assign ram_ok = (region == mem_pkg::REGION_RAM) && !misaligned;

  // Errors wait for an empty pipe so answers stay in order
  assign req_ready_o = (state_q == IDLE) && (outstanding < CNT_W'(CREDITS)) &&
                       (ram_ok ? (credit != '0) : (outstanding == '0));
  assign req_fire    = req_valid_i && req_ready_o;
  assign rsp_fire    = rsp_valid_o && rsp_ready_i;
  assign rq_pop      = rsp_fire && (state_q == IDLE);

  always_ff @(posedge HCLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q      <= IDLE;
      outstanding  <= '0;
      credit       <= CNT_W'(CREDITS);
      mreq_valid_o <= 1'b0;
      rq_count     <= '0;
      wr_ptr       <= '0;
      rd_ptr       <= '0;
    end else begin
      mreq_valid_o <= req_fire && ram_ok;
      outstanding  <= outstanding + CNT_W'(req_fire) - CNT_W'(rsp_fire);
      credit       <= credit + CNT_W'(crd_i) - CNT_W'(req_fire && ram_ok);
      rq_count     <= rq_count + CNT_W'(mrsp_valid_i) - CNT_W'(rq_pop);
      if (mrsp_valid_i) begin
        wr_ptr <= PTR_W'((int'(wr_ptr) + 1) % CREDITS);
      end
      if (rq_pop) begin
        rd_ptr <= PTR_W'((int'(rd_ptr) + 1) % CREDITS);
      end
      case (state_q)
        IDLE:    if (req_fire && !ram_ok) state_q <= ERR_RSP;
        ERR_RSP: if (rsp_ready_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request address and returned words
  always_ff @(posedge HCLK) begin
    if (req_fire) begin
      maddr_o <= addr_i;
    end
    if (mrsp_valid_i) begin
      rq_data[wr_ptr] <= mrsp_data_i;
    end
  end

  assign rsp_valid_o = (state_q == ERR_RSP) || (rq_count != '0);

  always_comb begin
    rsp_o.rdata = rq_data[rd_ptr];
    rsp_o.resp  = mem_pkg::RESP_OKAY;
    if (state_q == ERR_RSP) begin
      rsp_o.rdata = '0;
      rsp_o.resp  = mem_pkg::RESP_SLVERR;
    end
  end

endmodule

/* design/load_store_port.sv */
//////////////////////////////
// Load/store port
// RAM traffic under credit control, TOHOST/UART capture,
// local error answers
//////////////////////////////

module load_store_port #(
  parameter int RAM_WORDS = 256,
  parameter int CREDITS   = 2
) (
  input  logic              HCLK,
  input  logic              arst_n_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  mem_pkg::mem_req_t req_i,
  output logic              rsp_valid_o,
  input  logic              rsp_ready_i,
  output mem_pkg::mem_rsp_t rsp_o,
  output logic              tohost_valid_o,
  output mem_pkg::data_t    tohost_o,
  output logic              uart_valid_o,
  output mem_pkg::byte_t    uart_byte_o,
  output logic              mreq_valid_o,
  output mem_pkg::mem_req_t mreq_o,
  input  logic              crd_i,
  input  logic              mrsp_valid_i,
  input  mem_pkg::data_t    mrsp_data_i
);

  localparam int CNT_W = $clog2(CREDITS + 1);
  localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;

  typedef enum logic {IDLE, LOCAL_RSP} state_e;

  state_e           state_q;
  mem_pkg::region_t region;
  logic             misaligned;
  logic             ram_ok;
  logic             mmio_wr;
  logic             req_fire;
  logic             rsp_fire;
  logic             rq_pop;
  mem_pkg::resp_t   local_resp;
  logic [CNT_W-1:0] outstanding;
  logic [CNT_W-1:0] credit;
  logic [CNT_W-1:0] rq_count;
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  mem_pkg::data_t   rq_data [CREDITS];

  pma_check #(.RAM_WORDS(RAM_WORDS)) u_pma (
    .addr_i       (req_i.addr),
    .region_o     (region),
    .misaligned_o (misaligned)
  );

  //////////////////////////////
  // Request classification
  //////////////////////////////

  assign ram_ok  = (region == mem_pkg::REGION_RAM) && !misaligned;

  // IO regions only accept aligned writes
  assign mmio_wr = req_i.we && !misaligned &&
                   ((region == mem_pkg::REGION_TOHOST) ||
                    (region == mem_pkg::REGION_UART));

  // Local answers need an empty pipe to keep response order
  assign req_ready_o = (state_q == IDLE) && (outstanding < CNT_W'(CREDITS)) &&
                       (ram_ok ? (credit != '0) : (outstanding == '0));
  assign req_fire    = req_valid_i && req_ready_o;
  assign rsp_fire    = rsp_valid_o && rsp_ready_i;
  assign rq_pop      = rsp_fire && (state_q == IDLE);

  //////////////////////////////
  // Control state
  //////////////////////////////

  always_ff @(posedge HCLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q        <= IDLE;
      outstanding    <= '0;
      credit         <= CNT_W'(CREDITS);
      mreq_valid_o   <= 1'b0;
      tohost_valid_o <= 1'b0;
      uart_valid_o   <= 1'b0;
      rq_count       <= '0;
      wr_ptr         <= '0;
      rd_ptr         <= '0;
    end else begin
      mreq_valid_o   <= req_fire && ram_ok;
      // MMIO pulses line up with the local response
      tohost_valid_o <= req_fire && mmio_wr && (region == mem_pkg::REGION_TOHOST);
      uart_valid_o   <= req_fire && mmio_wr && (region == mem_pkg::REGION_UART);
      outstanding    <= outstanding + CNT_W'(req_fire) - CNT_W'(rsp_fire);
      credit         <= credit + CNT_W'(crd_i) - CNT_W'(req_fire && ram_ok);
      rq_count       <= rq_count + CNT_W'(mrsp_valid_i) - CNT_W'(rq_pop);
      if (mrsp_valid_i) begin
        wr_ptr <= PTR_W'((int'(wr_ptr) + 1) % CREDITS);
      end
      if (rq_pop) begin
        rd_ptr <= PTR_W'((int'(rd_ptr) + 1) % CREDITS);
      end
      case (state_q)
        IDLE:      if (req_fire && !ram_ok) state_q <= LOCAL_RSP;
        LOCAL_RSP: if (rsp_ready_i) state_q <= IDLE;
        default:   state_q <= IDLE;
      endcase
    end
  end

  // Payloads, loaded on acceptance
  always_ff @(posedge HCLK) begin
    if (req_fire) begin
      mreq_o      <= req_i;
      tohost_o    <= req_i.wdata;
      uart_byte_o <= req_i.wdata[7:0];
      local_resp  <= mmio_wr ? mem_pkg::RESP_OKAY : mem_pkg::RESP_SLVERR;
    end
    if (mrsp_valid_i) begin
      rq_data[wr_ptr] <= mrsp_data_i;
    end
  end

  //////////////////////////////
  // Response mux
  //////////////////////////////

  assign rsp_valid_o = (state_q == LOCAL_RSP) || (rq_count != '0);

  // RAM writes come back with zero data from the memory
  always_comb begin
    rsp_o.rdata = rq_data[rd_ptr];
    rsp_o.resp  = mem_pkg::RESP_OKAY;
    if (state_q == LOCAL_RSP) begin
      rsp_o.rdata = '0;
      rsp_o.resp  = local_resp;
    end
  end

endmodule

/* design/mem_pkg.sv */
//////////////////////////////
// Memory subsystem package
// Widths, bus structs, response and region codes, fixed memory map
//////////////////////////////

package mem_pkg;

  //////////////////////////////
  // Basic widths
  //////////////////////////////

  // Byte address
  typedef logic [31:0] addr_t;

  // Data word and its byte strobes
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // UART transmit character
  typedef logic [7:0]  byte_t;

  // Response code, AXI encoding
  typedef logic [1:0]  resp_t;

  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_SLVERR = 2'd2;

  //////////////////////////////
  // Region classes
  //////////////////////////////

  typedef logic [1:0]  region_t;

  // Main memory, read/write/execute
  localparam region_t REGION_RAM    = 2'd0;
  // IO blocks, write only
  localparam region_t REGION_TOHOST = 2'd1;
  localparam region_t REGION_UART   = 2'd2;
  // Anything not mapped
  localparam region_t REGION_NONE   = 2'd3;

  // Memory map; RAM length is set by RAM_WORDS
  localparam addr_t RAM_BASE     = 32'h8000_0000;
  localparam addr_t TOHOST_ADDR  = 32'h8000_1000;
  localparam addr_t UART_TX_ADDR = 32'h8000_1080;

  //////////////////////////////
  // Bus payloads
  //////////////////////////////

  // Load/store request, 69 bits
  typedef struct packed {
    addr_t addr;
    logic  we;
    data_t wdata;
    strb_t strb;
  } mem_req_t;

  // Response to either port, 34 bits
  typedef struct packed {
    data_t rdata;
    resp_t resp;
  } mem_rsp_t;

endpackage

/* design/mem_subsys_top.sv */
//////////////////////////////
// Memory subsystem top level
// Fetch and load/store ports over a unified memory
//////////////////////////////

module mem_subsys_top #(
  parameter int RAM_WORDS = 256,
  parameter int CREDITS   = 2
) (
  input  logic              HCLK,
  input  logic              arst_n_i,
  input  logic              ins_req_valid_i,
  output logic              ins_req_ready_o,
  input  mem_pkg::addr_t    ins_addr_i,
  output logic              ins_rsp_valid_o,
  input  logic              ins_rsp_ready_i,
  output mem_pkg::mem_rsp_t ins_rsp_o,
  input  logic              dat_req_valid_i,
  output logic              dat_req_ready_o,
  input  mem_pkg::mem_req_t dat_req_i,
  output logic              dat_rsp_valid_o,
  input  logic              dat_rsp_ready_i,
  output mem_pkg::mem_rsp_t dat_rsp_o,
  output logic              tohost_valid_o,
  output mem_pkg::data_t    tohost_o,
  output logic              uart_valid_o,
  output mem_pkg::byte_t    uart_byte_o
);

  // Fetch port to memory
  logic              ins_mreq_valid;
  mem_pkg::addr_t    ins_maddr;
  logic              ins_crd;
  logic              ins_mrsp_valid;
  mem_pkg::data_t    ins_mrsp_data;

  // Load/store port to memory
  logic              dat_mreq_valid;
  mem_pkg::mem_req_t dat_mreq;
  logic              dat_crd;
  logic              dat_mrsp_valid;
  mem_pkg::data_t    dat_mrsp_data;

  fetch_port #(.RAM_WORDS(RAM_WORDS), .CREDITS(CREDITS)) u_fetch (
    .HCLK         (HCLK),
    .arst_n_i     (arst_n_i),
    .req_valid_i  (ins_req_valid_i),
    .req_ready_o  (ins_req_ready_o),
    .addr_i       (ins_addr_i),
    .rsp_valid_o  (ins_rsp_valid_o),
    .rsp_ready_i  (ins_rsp_ready_i),
    .rsp_o        (ins_rsp_o),
    .mreq_valid_o (ins_mreq_valid),
    .maddr_o      (ins_maddr),
    .crd_i        (ins_crd),
    .mrsp_valid_i (ins_mrsp_valid),
    .mrsp_data_i  (ins_mrsp_data)
  );

  load_store_port #(.RAM_WORDS(RAM_WORDS), .CREDITS(CREDITS)) u_lsu (
    .HCLK           (HCLK),
    .arst_n_i       (arst_n_i),
    .req_valid_i    (dat_req_valid_i),
    .req_ready_o    (dat_req_ready_o),
    .req_i          (dat_req_i),
    .rsp_valid_o    (dat_rsp_valid_o),
    .rsp_ready_i    (dat_rsp_ready_i),
    .rsp_o          (dat_rsp_o),
    .tohost_valid_o (tohost_valid_o),
    .tohost_o       (tohost_o),
    .uart_valid_o   (uart_valid_o),
    .uart_byte_o    (uart_byte_o),
    .mreq_valid_o   (dat_mreq_valid),
    .mreq_o         (dat_mreq),
    .crd_i          (dat_crd),
    .mrsp_valid_i   (dat_mrsp_valid),
    .mrsp_data_i    (dat_mrsp_data)
  );

  unified_mem #(.RAM_WORDS(RAM_WORDS), .CREDITS(CREDITS)) u_mem (
    .HCLK            (HCLK),
    .arst_n_i        (arst_n_i),
    .ins_req_valid_i (ins_mreq_valid),
    .ins_addr_i      (ins_maddr),
    .ins_crd_o       (ins_crd),
    .ins_rsp_valid_o (ins_mrsp_valid),
    .ins_rsp_data_o  (ins_mrsp_data),
    .dat_req_valid_i (dat_mreq_valid),
    .dat_req_i       (dat_mreq),
    .dat_crd_o       (dat_crd),
    .dat_rsp_valid_o (dat_mrsp_valid),
    .dat_rsp_data_o  (dat_mrsp_data)
  );

endmodule

/* design/pma_check.sv */
//////////////////////////////
// Physical memory attributes
// Maps an address to its region and flags misalignment
//////////////////////////////

module pma_check #(
  parameter int RAM_WORDS = 256
) (
  input  mem_pkg::addr_t   addr_i,
  output mem_pkg::region_t region_o,
  output logic             misaligned_o
);

  // RAM length in bytes
  localparam mem_pkg::addr_t RAM_BYTES = mem_pkg::addr_t'(RAM_WORDS * 4);

  mem_pkg::addr_t ram_off;
  logic           in_ram;
  logic           in_tohost;
  logic           in_uart;

  //////////////////////////////
  // Range compares
  //////////////////////////////

  // Offset from the RAM base, wraps below it
  assign ram_off = addr_i - mem_pkg::RAM_BASE;
  assign in_ram  = (addr_i >= mem_pkg::RAM_BASE) && (ram_off < RAM_BYTES);

  // TOHOST is a 16-byte aligned block
  assign in_tohost = (addr_i[31:4] == mem_pkg::TOHOST_ADDR[31:4]);

  // UART transmit is one word
  assign in_uart = (addr_i[31:2] == mem_pkg::UART_TX_ADDR[31:2]);

  // IO blocks win in case RAM is configured large enough to cover them
  always_comb begin
    if (in_tohost) begin
      region_o = mem_pkg::REGION_TOHOST;
    end else if (in_uart) begin
      region_o = mem_pkg::REGION_UART;
    end else if (in_ram) begin
      region_o = mem_pkg::REGION_RAM;
    end else begin
      region_o = mem_pkg::REGION_NONE;
    end
  end

  // Only word accesses are supported
  assign misaligned_o = |addr_i[1:0];

endmodule

/* design/unified_mem.sv */
//////////////////////////////
// Unified memory
// Two request queues, round-robin service, shared RAM
//////////////////////////////

module unified_mem #(
  parameter int RAM_WORDS = 256,
  parameter int CREDITS   = 2
) (
  input  logic              HCLK,
  input  logic              arst_n_i,
  input  logic              ins_req_valid_i,
  input  mem_pkg::addr_t    ins_addr_i,
  output logic              ins_crd_o,
  output logic              ins_rsp_valid_o,
  output mem_pkg::data_t    ins_rsp_data_o,
  input  logic              dat_req_valid_i,
  input  mem_pkg::mem_req_t dat_req_i,
  output logic              dat_crd_o,
  output logic              dat_rsp_valid_o,
  output mem_pkg::data_t    dat_rsp_data_o
);

  localparam int CNT_W = $clog2(CREDITS + 1);
  localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
  localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  // Index 0 is the fetch port, 1 the load/store port
  mem_pkg::mem_req_t req_in [2];
  mem_pkg::mem_req_t q_head [2];
  logic [1:0]        req_vld;
  logic [1:0]        q_nempty;
  logic [1:0]        grant;
  logic              prio_dat;
  mem_pkg::mem_req_t svc_req;
  mem_pkg::addr_t    svc_off;
  logic [IDX_W-1:0]  svc_idx;
  logic [1:0]        rsp_vld;
  mem_pkg::data_t    rsp_data [2];
  mem_pkg::data_t    ram [RAM_WORDS];

  // Fetches travel as plain reads
  always_comb begin
    req_in[0].addr  = ins_addr_i;
    req_in[0].we    = 1'b0;
    req_in[0].wdata = '0;
    req_in[0].strb  = '0;
    req_in[1]       = dat_req_i;
  end

  assign req_vld = {dat_req_valid_i, ins_req_valid_i};

  //////////////////////////////
  // Request queues
  //////////////////////////////

  for (genvar p = 0; p < 2; p++) begin : g_queue
    mem_pkg::mem_req_t slots [CREDITS];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;

    always_ff @(posedge HCLK or negedge arst_n_i) begin
      if (!arst_n_i) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
      end else begin
        if (req_vld[p]) begin
          wr_ptr <= PTR_W'((int'(wr_ptr) + 1) % CREDITS);
        end
        if (grant[p]) begin
          rd_ptr <= PTR_W'((int'(rd_ptr) + 1) % CREDITS);
        end
        count <= count + CNT_W'(req_vld[p]) - CNT_W'(grant[p]);
      end
    end

    always_ff @(posedge HCLK) begin
      if (req_vld[p]) begin
        slots[wr_ptr] <= req_in[p];
      end
    end

    assign q_nempty[p] = (count != '0);
    assign q_head[p]   = slots[rd_ptr];
  end

  //////////////////////////////
  // Round-robin arbiter
  //////////////////////////////

  always_comb begin
    grant = 2'b00;
    if (q_nempty[0] && (!q_nempty[1] || !prio_dat)) begin
      grant[0] = 1'b1;
    end else if (q_nempty[1]) begin
      grant[1] = 1'b1;
    end
  end

  // Priority passes to the port that was not served
  always_ff @(posedge HCLK or negedge arst_n_i) begin
    if (!arst_n_i) begin
      prio_dat <= 1'b0;
      rsp_vld  <= 2'b00;
    end else begin
      rsp_vld <= grant;
      if (grant[0]) begin
        prio_dat <= 1'b1;
      end else if (grant[1]) begin
        prio_dat <= 1'b0;
      end
    end
  end

  assign ins_crd_o = grant[0];
  assign dat_crd_o = grant[1];

  //////////////////////////////
  // RAM access
  //////////////////////////////

  assign svc_req = grant[1] ? q_head[1] : q_head[0];
  assign svc_off = svc_req.addr - mem_pkg::RAM_BASE;
  assign svc_idx = svc_off[IDX_W+1:2];

  always_ff @(posedge HCLK) begin
    if ((|grant) && svc_req.we) begin
      for (int b = 0; b < 4; b++) begin
        if (svc_req.strb[b]) begin
          ram[svc_idx][8*b +: 8] <= svc_req.wdata[8*b +: 8];
        end
      end
    end
    // Writes answer with zero data
    for (int p = 0; p < 2; p++) begin
      if (grant[p]) begin
        rsp_data[p] <= svc_req.we ? '0 : ram[svc_idx];
      end
    end
  end

  assign ins_rsp_valid_o = rsp_vld[0];
  assign ins_rsp_data_o  = rsp_data[0];
  assign dat_rsp_valid_o = rsp_vld[1];
  assign dat_rsp_data_o  = rsp_data[1];

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the memory subsystem testbench with Verilator and run it
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_mem_subsys -f sim.f -o tb_sim \
  || { echo "Build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
grep -q -F "*** TEST FAILED ***" sim.log && { echo "Simulation failed"; exit 1; }
grep -q -F "*** TEST PASSED ***" sim.log || { echo "Simulation did not finish"; exit 1; }
echo "Simulation passed"
exit 0

/* sim.f */
design/mem_pkg.sv
design/pma_check.sv
design/fetch_port.sv
design/load_store_port.sv
design/unified_mem.sv
design/mem_subsys_top.sv
+incdir+test
test/tb_mem_subsys.sv

/* test/tb_ref_model.svh */
//////////////////////////////
// Memory subsystem reference model
// Random source, shadow RAM and expected responses
//////////////////////////////

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam int          REF_WORDS = 256;
localparam logic [31:0] SEED      = 32'h9f40_aa74;

mem_pkg::data_t shadow_ram [REF_WORDS];
mem_pkg::data_t exp_tohost_q [$];
mem_pkg::byte_t exp_uart_q [$];

// Next state of a 32-bit xorshift generator
function automatic logic [31:0] xorshift32(logic [31:0] x);
  logic [31:0] v;
  v = x;
  v = v ^ (v << 13);
  v = v ^ (v >> 17);
  v = v ^ (v << 5);
  return v;
endfunction

// Byte address of a RAM word
function automatic mem_pkg::addr_t ram_addr(int idx);
  return mem_pkg::RAM_BASE + mem_pkg::addr_t'(idx << 2);
endfunction

// Initial contents, built from the full address
function automatic mem_pkg::data_t fill_word(int idx);
  mem_pkg::addr_t a;
  a = ram_addr(idx);
  return {a[15:0], a[31:16]} ^ 32'hc3a5_0f96;
endfunction

// Region of an address from the fixed memory map
function automatic mem_pkg::region_t ref_region(mem_pkg::addr_t a);
  if (a >= mem_pkg::TOHOST_ADDR && a < mem_pkg::TOHOST_ADDR + 32'd16) begin
    return mem_pkg::REGION_TOHOST;
  end
  if (a >= mem_pkg::UART_TX_ADDR && a < mem_pkg::UART_TX_ADDR + 32'd4) begin
    return mem_pkg::REGION_UART;
  end
  if (a >= mem_pkg::RAM_BASE && a < mem_pkg::RAM_BASE + 32'(REF_WORDS * 4)) begin
    return mem_pkg::REGION_RAM;
  end
  return mem_pkg::REGION_NONE;
endfunction

// Expected load/store answer; updates the shadow state
function automatic mem_pkg::mem_rsp_t ref_data_rsp(mem_pkg::mem_req_t r);
  mem_pkg::mem_rsp_t rsp;
  int                idx;
  rsp.rdata = '0;
  rsp.resp  = mem_pkg::RESP_SLVERR;
  idx = int'((r.addr - mem_pkg::RAM_BASE) >> 2);
  if (r.addr[1:0] != 2'b00) begin
    return rsp;
  end
  case (ref_region(r.addr))
    mem_pkg::REGION_RAM: begin
      rsp.resp = mem_pkg::RESP_OKAY;
      if (r.we) begin
        for (int b = 0; b < 4; b++) begin
          if (r.strb[b]) begin
            shadow_ram[idx][8*b +: 8] = r.wdata[8*b +: 8];
          end
        end
      end else begin
        rsp.rdata = shadow_ram[idx];
      end
    end
    mem_pkg::REGION_TOHOST: begin
      if (r.we) begin
        rsp.resp = mem_pkg::RESP_OKAY;
        exp_tohost_q.push_back(r.wdata);
      end
    end
    mem_pkg::REGION_UART: begin
      if (r.we) begin
        rsp.resp = mem_pkg::RESP_OKAY;
        exp_uart_q.push_back(r.wdata[7:0]);
      end
    end
    default: begin
    end
  endcase
  return rsp;
endfunction

// Expected fetch answer, only aligned RAM words are executable
function automatic mem_pkg::mem_rsp_t ref_fetch_rsp(mem_pkg::addr_t a);
  mem_pkg::mem_rsp_t rsp;
  rsp.rdata = '0;
  rsp.resp  = mem_pkg::RESP_SLVERR;
  if (a[1:0] == 2'b00 && ref_region(a) == mem_pkg::REGION_RAM) begin
    rsp.resp  = mem_pkg::RESP_OKAY;
    rsp.rdata = shadow_ram[int'((a - mem_pkg::RAM_BASE) >> 2)];
  end
  return rsp;
endfunction

`endif

/* test/tb_mem_subsys.sv */
//////////////////////////////
// Memory subsystem testbench
// Random traffic on both ports against a shadow RAM
//////////////////////////////

module tb_mem_subsys;

  localparam int RAM_WORDS   = 256;
  localparam int CREDITS     = 2;
  localparam int CYCLE_LIMIT = 20000;
  localparam int N_RANDOM    = 200;
  localparam int N_CONC      = 300;

  logic              HCLK;
  logic              arst_n_i;
  logic              ins_req_valid_i;
  logic              ins_req_ready_o;
  mem_pkg::addr_t    ins_addr_i;
  logic              ins_rsp_valid_o;
  logic              ins_rsp_ready_i;
  mem_pkg::mem_rsp_t ins_rsp_o;
  logic              dat_req_valid_i;
  logic              dat_req_ready_o;
  mem_pkg::mem_req_t dat_req_i;
  logic              dat_rsp_valid_o;
  logic              dat_rsp_ready_i;
  mem_pkg::mem_rsp_t dat_rsp_o;
  logic              tohost_valid_o;
  mem_pkg::data_t    tohost_o;
  logic              uart_valid_o;
  mem_pkg::byte_t    uart_byte_o;

  mem_pkg::mem_rsp_t exp_ins_q [$];
  mem_pkg::mem_rsp_t exp_dat_q [$];
  logic [31:0]       ins_rng;
  logic [31:0]       dat_rng;
  logic [31:0]       bp_rng;
  logic              ins_hold;
  int                cycles;

  `include "tb_ref_model.svh"

  mem_subsys_top #(.RAM_WORDS(RAM_WORDS), .CREDITS(CREDITS)) dut0 (.*);

  initial begin
    HCLK = 1'b0;
    forever #20 HCLK = ~HCLK;
  end

  task automatic check_value(string name, logic [63:0] exp_v, logic [63:0] act_v);
    assert (act_v === exp_v) else begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, exp_v, act_v);
      $display("*** TEST FAILED ***");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "run aborted");
  endtask

  // Watchdog
  always @(posedge HCLK) begin
    cycles = cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      abort_run("Timeout: the run did not finish within the cycle limit");
    end
  end

  // Random response back-pressure
  // The fetch side can also be held off completely
  always @(negedge HCLK) begin
    bp_rng = xorshift32(bp_rng);
    ins_rsp_ready_i = !ins_hold && (bp_rng[1:0] != 2'b00);
    dat_rsp_ready_i = (bp_rng[3:2] != 2'b00);
  end

  //////////////////////////////
  // Compare process
  //////////////////////////////

  always @(negedge HCLK) begin
    #1;
    if (arst_n_i) begin
      if (ins_rsp_valid_o && ins_rsp_ready_i) begin
        assert (exp_ins_q.size() != 0) else begin
          abort_run("Fetch port answered with nothing outstanding");
        end
        check_value("ins_rsp_o", 64'(exp_ins_q.pop_front()), 64'(ins_rsp_o));
      end
      if (dat_rsp_valid_o && dat_rsp_ready_i) begin
        assert (exp_dat_q.size() != 0) else begin
          abort_run("Data port answered with nothing outstanding");
        end
        check_value("dat_rsp_o", 64'(exp_dat_q.pop_front()), 64'(dat_rsp_o));
      end
      if (tohost_valid_o) begin
        assert (exp_tohost_q.size() != 0) else begin
          abort_run("Unexpected tohost pulse");
        end
        check_value("tohost_o", 64'(exp_tohost_q.pop_front()), 64'(tohost_o));
      end
      if (uart_valid_o) begin
        assert (exp_uart_q.size() != 0) else begin
          abort_run("Unexpected uart pulse");
        end
        check_value("uart_byte_o", 64'(exp_uart_q.pop_front()), 64'(uart_byte_o));
      end
    end
  end

  //////////////////////////////
  // Request drivers
  //////////////////////////////

  task automatic fetch(mem_pkg::addr_t a);
    logic done;
    done = 1'b0;
    while (!done) begin
      @(negedge HCLK);
      ins_req_valid_i = 1'b1;
      ins_addr_i      = a;
      #1;
      if (ins_req_ready_o) begin
        exp_ins_q.push_back(ref_fetch_rsp(a));
        done = 1'b1;
      end
    end
    @(posedge HCLK);
  endtask

  task automatic data_req(mem_pkg::mem_req_t r);
    logic done;
    done = 1'b0;
    while (!done) begin
      @(negedge HCLK);
      dat_req_valid_i = 1'b1;
      dat_req_i       = r;
      #1;
      if (dat_req_ready_o) begin
        exp_dat_q.push_back(ref_data_rsp(r));
        done = 1'b1;
      end
    end
    @(posedge HCLK);
  endtask

  task automatic end_fetch();
    @(negedge HCLK);
    ins_req_valid_i = 1'b0;
  endtask

  task automatic end_data();
    @(negedge HCLK);
    dat_req_valid_i = 1'b0;
  endtask

  task automatic data_op(mem_pkg::addr_t a, logic we, mem_pkg::data_t wd, mem_pkg::strb_t st);
    mem_pkg::mem_req_t r;
    r.addr  = a;
    r.we    = we;
    r.wdata = wd;
    r.strb  = st;
    data_req(r);
  endtask

  // Writes go to the upper half when fetches may run alongside
  task automatic random_data_op(logic upper_only);
    int idx;
    logic we;
    dat_rng = xorshift32(dat_rng);
    we  = dat_rng[31];
    idx = (we && upper_only) ? 128 + int'(dat_rng[6:0]) : int'(dat_rng[7:0]);
    data_op(ram_addr(idx), we, xorshift32(dat_rng ^ 32'h1234_5678), dat_rng[11:8]);
  endtask

  task automatic random_fetch();
    ins_rng = xorshift32(ins_rng);
    fetch(ram_addr(int'(ins_rng[6:0])));
  endtask

  task automatic wait_drain();
    while (exp_ins_q.size() != 0 || exp_dat_q.size() != 0 ||
           exp_tohost_q.size() != 0 || exp_uart_q.size() != 0) begin
      @(negedge HCLK);
    end
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    arst_n_i = 1'b0;
    ins_req_valid_i = 1'b0;
    ins_addr_i = '0;
    ins_rsp_ready_i = 1'b0;
    dat_req_valid_i = 1'b0;
    dat_req_i = '0;
    dat_rsp_ready_i = 1'b0;
    ins_hold = 1'b0;
    ins_rng = SEED;
    dat_rng = xorshift32(SEED);
    bp_rng = xorshift32(dat_rng);
    repeat (4) @(negedge HCLK);
    arst_n_i = 1'b1;
    @(negedge HCLK);
    #1;
    check_value("ins_rsp_valid_o", 64'd0, 64'(ins_rsp_valid_o));
    check_value("dat_rsp_valid_o", 64'd0, 64'(dat_rsp_valid_o));
    check_value("tohost_valid_o", 64'd0, 64'(tohost_valid_o));
    check_value("uart_valid_o", 64'd0, 64'(uart_valid_o));
    check_value("ins_req_ready_o", 64'd1, 64'(ins_req_ready_o));
    check_value("dat_req_ready_o", 64'd1, 64'(dat_req_ready_o));

    // Fill RAM before random strobed writes and reads
    for (int i = 0; i < RAM_WORDS; i++) begin
      data_op(ram_addr(i), 1'b1, fill_word(i), 4'hf);
    end
    for (int n = 0; n < N_RANDOM; n++) begin
      random_data_op(1'b0);
    end
    end_data();
    wait_drain();

    // Both ports at once
    fork
      begin
        for (int n = 0; n < N_CONC; n++) begin
          random_fetch();
        end
        end_fetch();
      end
      begin
        for (int n = 0; n < N_CONC; n++) begin
          random_data_op(1'b1);
        end
        end_data();
      end
    join

    // MMIO writes leave RAM unchanged
    for (int n = 0; n < 8; n++) begin
      dat_rng = xorshift32(dat_rng);
      data_op(mem_pkg::TOHOST_ADDR + 32'(n % 4 * 4), 1'b1, dat_rng, 4'hf);
      data_op(mem_pkg::UART_TX_ADDR, 1'b1, ~dat_rng, 4'hf);
      data_op(ram_addr(n), 1'b0, '0, '0);
    end

    // Error answers with no side effect
    data_op(mem_pkg::TOHOST_ADDR, 1'b0, '0, '0);
    data_op(mem_pkg::UART_TX_ADDR, 1'b0, '0, '0);
    data_op(32'h0000_1000, 1'b1, 32'hdead_beef, 4'hf);
    data_op(32'h9000_0000, 1'b0, '0, '0);
    data_op(ram_addr(RAM_WORDS), 1'b1, 32'h0bad_f00d, 4'hf);
    data_op(ram_addr(9) + 32'd2, 1'b1, 32'hffff_ffff, 4'hf);
    data_op(mem_pkg::TOHOST_ADDR + 32'd1, 1'b1, 32'h5555_aaaa, 4'hf);
    data_op(ram_addr(9), 1'b0, '0, '0);
    // Word 0 is where a wrongly forwarded write would land
    data_op(ram_addr(0), 1'b0, '0, '0);
    end_data();
    fetch(mem_pkg::TOHOST_ADDR);
    fetch(32'h0000_0000);
    fetch(ram_addr(3) + 32'd1);
    fetch(ram_addr(RAM_WORDS));
    fetch(ram_addr(3));
    end_fetch();
    wait_drain();

    // Fetch responses held off while the data port keeps going
    ins_hold = 1'b1;
    fetch(ram_addr(17));
    fetch(ram_addr(18));
    @(negedge HCLK);
    ins_req_valid_i = 1'b0;
    ins_addr_i = ram_addr(19);
    #1;
    check_value("ins_req_ready_o", 64'd0, 64'(ins_req_ready_o));
    for (int n = 0; n < 20; n++) begin
      random_data_op(1'b1);
    end
    end_data();
    #1;
    check_value("ins_req_ready_o", 64'd0, 64'(ins_req_ready_o));
    check_value("ins_rsp_valid_o", 64'd1, 64'(ins_rsp_valid_o));
    ins_hold = 1'b0;
    wait_drain();
    #1;
    check_value("ins_req_ready_o", 64'd1, 64'(ins_req_ready_o));

    repeat (4) @(negedge HCLK);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule
